// File: complexExecStage.f
+incdir+include
design/recoveryPkg.sv
design/complexOpPkg.sv
design/pipelinedMultiplier.sv
design/iterativeDivider.sv
design/complexExecStage.sv
testbench/complexExecStageTb.sv

// File: design/complexExecStage.sv
/* Complex integer execution stage for a single issue lane: multiplies run through
   the local pipeline, divides go through the shared divider with a replay pass. */
`timescale 1ns/1ps

module complexExecStage #(
    parameter int execDepth = 3,
    parameter int divCycles = 32
) (
    input  logic                     clk,
    input  logic                     arstN,
    input  logic                     stall,
    input  logic                     clear,
    input  complexOpPkg::complexEntry issue,
    input  recoveryPkg::flushRange   flushReq,
    output complexOpPkg::execResult  result,
    output logic                     replayValid,
    output complexOpPkg::complexEntry replayEntry,
    output logic                     divBusy,
    output logic                     divFinished
);
    import complexOpPkg::*;
    import recoveryPkg::*;

    localparam int lastStage = execDepth - 2;

    if (execDepth < 2) begin : depthCheck
        $error("execDepth must be at least 2");
    end

    typedef struct packed {
        logic        valid;
        logic        ready;
        complexEntry entry;
    } localStage;

    complexEntry                entryReg;
    localStage [lastStage:0]    stages;
    localStage [lastStage:0]    nextStages;
    localStage                  lastEntry;

    logic                 entryFlush;
    logic [lastStage:0]   stageFlush;
    logic                 entryIsDiv;
    logic                 operandsReady;
    logic                 entryReady;
    mulInfo               entryMul;
    divInfo               entryDiv;

    logic                 divReq;
    logic                 divReset;
    logic                 divRelease;
    logic                 ownerValid;
    activeListPtr         ownerPtr;
    logic [31:0]          product;
    logic [31:0]          quotientOut;

    // Flush hits for the entry register and every local stage
    always_comb begin
        entryFlush = inFlushRange(flushReq, entryReg.activeListPtr);
        for (int j = 0; j <= lastStage; j++) begin
            stageFlush[j] = inFlushRange(flushReq, stages[j].entry.activeListPtr);
        end
    end

    always_comb begin
        entryIsDiv = (entryReg.opType == opDiv);
        entryMul = entryReg.opInfo.asMul;
        entryDiv = entryReg.opInfo.asDiv;
        operandsReady = entryReg.operandA.ready && entryReg.operandB.ready;

        // A divide has data only on its replayed pass with the result waiting
        entryReady = entryIsDiv ? (entryReg.replay && divFinished) : operandsReady;

        divReq = entryReg.valid && entryIsDiv && !entryReg.replay && operandsReady &&
                 !ownerValid && !entryFlush && !stall && !clear;

        divReset = clear ||
                   (ownerValid && inFlushRange(flushReq, ownerPtr)) ||
                   (entryReg.valid && entryIsDiv && entryFlush);

        nextStages[0].valid = entryReg.valid && !entryFlush;
        nextStages[0].ready = entryReady;
        nextStages[0].entry = entryReg;
        for (int j = 1; j <= lastStage; j++) begin
            nextStages[j] = stages[j-1];
            nextStages[j].valid = stages[j-1].valid && !stageFlush[j-1];
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            entryReg <= '0;
            stages <= '0;
        end
        else if (clear) begin
            entryReg.valid <= 1'b0;
            for (int j = 0; j <= lastStage; j++) begin
                stages[j].valid <= 1'b0;
            end
        end
        else if (!stall) begin
            entryReg <= issue;
            stages <= nextStages;
        end
        else begin
            // Frozen, but flushed operations still drop out
            entryReg.valid <= entryReg.valid && !entryFlush;
            for (int j = 0; j <= lastStage; j++) begin
                stages[j].valid <= stages[j].valid && !stageFlush[j];
            end
        end
    end

    // Pointer of the divide that owns the divider
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            ownerValid <= 1'b0;
            ownerPtr <= '0;
        end
        else if (divReset) begin
            ownerValid <= 1'b0;
        end
        else if (divReq) begin
            ownerValid <= 1'b1;
            ownerPtr <= entryReg.activeListPtr;
        end
        else if (divRelease) begin
            ownerValid <= 1'b0;
        end
    end

    pipelinedMultiplier #(
        .execDepth(execDepth)
    ) mulUnit (
        .clk(clk),
        .arstN(arstN),
        .enable(!stall),
        .operandA(entryReg.operandA.data),
        .operandB(entryReg.operandB.data),
        .info(entryMul),
        .product(product)
    );

    iterativeDivider #(
        .divCycles(divCycles)
    ) divUnit (
        .clk(clk),
        .arstN(arstN),
        .enable(!stall),
        .divReq(divReq),
        .divReset(divReset),
        .divRelease(divRelease),
        .dividend(entryReg.operandA.data),
        .divisor(entryReg.operandB.data),
        .code(entryDiv.divCode),
        .busy(divBusy),
        .finished(divFinished),
        .quotientOut(quotientOut)
    );

    // Unready operations leave from the first local stage
    always_comb begin
        replayValid = !stall && !clear && stages[0].valid && !stageFlush[0] &&
                      !stages[0].ready;
        replayEntry = stages[0].entry;
    end

    always_comb begin
        lastEntry = stages[lastStage];
        result.valid = !stall && !clear && lastEntry.valid && !stageFlush[lastStage];
        result.dataValid = lastEntry.ready;
        result.data = (lastEntry.entry.opType == opDiv) ? quotientOut : product;
        result.activeListPtr = lastEntry.entry.activeListPtr;

        // Divide that collected its result frees the divider on the way out
        divRelease = result.valid && result.dataValid && (lastEntry.entry.opType == opDiv);
    end

    // Reservation held here must agree with the divider's own state
    noRequestWhileBusy: assert property (
        @(posedge clk) disable iff (!arstN)
        divReq |-> !divBusy && !divFinished
    );

endmodule

// File: design/complexOpPkg.sv
/* Operation encodings and the entry and result records of the complex execution stage.
   Imported by the stage and its multiplier and divider units. */
package complexOpPkg;

    typedef enum logic [1:0] {
        opMul = 2'd0,
        opDiv = 2'd1
    } complexOpType;

    // Signedness of the operands for the upper product
    typedef enum logic [1:0] {
        mulSignedSigned     = 2'd0,
        mulSignedUnsigned   = 2'd1,
        mulUnsignedUnsigned = 2'd2
    } mulCodeType;

    typedef enum logic [1:0] {
        div  = 2'd0,
        divu = 2'd1,
        rem  = 2'd2,
        remu = 2'd3
    } divCodeType;

    typedef struct packed {
        logic       getUpper;
        mulCodeType mulCode;
        logic       pad;
    } mulInfo;

    typedef struct packed {
        divCodeType divCode;
        logic [1:0] pad;
    } divInfo;

    // Same 4-bit word, read according to the operation type
    typedef union packed {
        mulInfo asMul;
        divInfo asDiv;
    } complexOpInfo;

    typedef struct packed {
        logic        ready;
        logic [31:0] data;
    } operandType;

    typedef struct packed {
        logic                      valid;
        logic                      replay;
        complexOpType              opType;
        complexOpInfo              opInfo;
        recoveryPkg::activeListPtr activeListPtr;
        operandType                operandA;
        operandType                operandB;
    } complexEntry;

    typedef struct packed {
        logic                      valid;
        logic                      dataValid;
        logic [31:0]               data;
        recoveryPkg::activeListPtr activeListPtr;
    } execResult;

endpackage

// File: design/iterativeDivider.sv
/* Radix-2 restoring divider reserved by one divide at a time.
   Holds its result in the finished state until released or reset by the stage. */
`timescale 1ns/1ps

module iterativeDivider #(
    parameter int divCycles = 32
) (
    input  logic                     clk,
    input  logic                     arstN,
    input  logic                     enable,
    input  logic                     divReq,
    input  logic                     divReset,
    input  logic                     divRelease,
    input  logic [31:0]              dividend,
    input  logic [31:0]              divisor,
    input  complexOpPkg::divCodeType code,
    output logic                     busy,
    output logic                     finished,
    output logic [31:0]              quotientOut
);
    import complexOpPkg::*;

    localparam int countWidth = $clog2(divCycles + 1);

    typedef enum logic [1:0] {
        stFree     = 2'd0,
        stBusy     = 2'd1,
        stFinished = 2'd2
    } divState;

    divState               state;
    logic [countWidth-1:0] iterCount;

    logic [31:0] quotReg;
    logic [31:0] remReg;
    logic [31:0] divisorReg;
    logic        wantRem;
    logic        negQuot;
    logic        negRem;

    logic        signedCode;
    logic        signA;
    logic        signB;
    logic [31:0] magA;
    logic [31:0] magB;
    logic [32:0] partial;
    logic [33:0] diff;

    always_comb begin
        signedCode = (code == div) || (code == rem);
        signA = signedCode & dividend[31];
        signB = signedCode & divisor[31];
        magA = signA ? -dividend : dividend;
        magB = signB ? -divisor : divisor;

        // Shift in the next dividend bit and try the subtraction
        partial = {remReg, quotReg[31]};
        diff = {1'b0, partial} - {2'b00, divisorReg};
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= stFree;
            iterCount <= '0;
        end
        else if (divReset) begin
            state <= stFree;
        end
        else if (enable) begin
            case (state)
                stFree: begin
                    if (divReq) begin
                        state <= stBusy;
                        iterCount <= countWidth'(divCycles);
                    end
                end
                stBusy: begin
                    iterCount <= iterCount - 1'b1;
                    if (iterCount == countWidth'(1)) begin
                        state <= stFinished;
                    end
                end
                stFinished: begin
                    if (divRelease) begin
                        state <= stFree;
                    end
                end
                default: state <= stFree;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (enable && state == stFree && divReq) begin
            quotReg <= magA;
            remReg <= '0;
            divisorReg <= magB;
            wantRem <= (code == rem) || (code == remu);
            // A zero divisor keeps the all-ones quotient unsigned
            negQuot <= (signA ^ signB) && (divisor != '0);
            negRem <= signA;
        end
        else if (enable && state == stBusy) begin
            quotReg <= {quotReg[30:0], ~diff[33]};
            remReg <= diff[33] ? partial[31:0] : diff[31:0];
        end
    end

    // Signed overflow falls out of the magnitude loop as dividend and zero
    always_comb begin
        if (wantRem) begin
            quotientOut = negRem ? -remReg : remReg;
        end
        else begin
            quotientOut = negQuot ? -quotReg : quotReg;
        end
    end

    assign busy = (state == stBusy);
    assign finished = (state == stFinished);

    // Only a divide that collected its result may free the unit
    releaseOnlyWhenFinished: assert property (
        @(posedge clk) disable iff (!arstN)
        divRelease |-> state == stFinished
    );

endmodule

// File: design/pipelinedMultiplier.sv
/* 32-bit multiplier returning the lower or upper product, pipelined to match the
   local stages of the complex execution stage. */
`timescale 1ns/1ps

module pipelinedMultiplier #(
    parameter int execDepth = 3
) (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 enable,
    input  logic [31:0]          operandA,
    input  logic [31:0]          operandB,
    input  complexOpPkg::mulInfo info,
    output logic [31:0]          product
);
    import complexOpPkg::*;

    // First stage is the combinational multiply beside the entry register
    localparam int regCount = execDepth - 1;

    logic                     signA;
    logic                     signB;
    logic signed [32:0]       extA;
    logic signed [32:0]       extB;
    logic signed [65:0]       fullProduct;
    logic [31:0]              selected;
    logic [regCount-1:0][31:0] stageProduct;

    always_comb begin
        case (info.mulCode)
            mulSignedSigned: begin
                signA = 1'b1;
                signB = 1'b1;
            end
            mulSignedUnsigned: begin
                signA = 1'b1;
                signB = 1'b0;
            end
            default: begin
                signA = 1'b0;
                signB = 1'b0;
            end
        endcase

        // One extra bit per operand covers both signed and unsigned ranges
        extA = $signed({signA & operandA[31], operandA});
        extB = $signed({signB & operandB[31], operandB});
        fullProduct = extA * extB;

        selected = info.getUpper ? fullProduct[63:32] : fullProduct[31:0];
    end

    // One product per stage, several multiplies may be in flight
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            stageProduct <= '0;
        end
        else if (enable) begin
            stageProduct[0] <= selected;
            for (int j = 1; j < regCount; j++) begin
                stageProduct[j] <= stageProduct[j-1];
            end
        end
    end

    assign product = stageProduct[regCount-1];

endmodule

// File: design/recoveryPkg.sv
/* Active-list pointer and flush-range definitions for selective recovery.
   Compile before any package or module that tags operations with a pointer. */
package recoveryPkg;

    // 64-entry active list
    typedef logic [5:0] activeListPtr;

    typedef struct packed {
        logic         active;
        logic         flushAll;
        activeListPtr headPtr;
        activeListPtr tailPtr;
    } flushRange;

    // Circular interval from head up to but not including tail
    function automatic logic inFlushRange(input flushRange range, input activeListPtr ptr);
        logic hit;
        if (!range.active) begin
            hit = 1'b0;
        end
        else if (range.flushAll) begin
            hit = 1'b1;
        end
        else if (range.headPtr < range.tailPtr) begin
            hit = (ptr >= range.headPtr) && (ptr < range.tailPtr);
        end
        else if (range.headPtr > range.tailPtr) begin
            // Range wraps past the top of the pointer space
            hit = (ptr >= range.headPtr) || (ptr < range.tailPtr);
        end
        else begin
            hit = 1'b0;
        end
        return hit;
    endfunction

endpackage

// File: run.sh
#!/bin/sh
# Build and run the complex execution stage testbench with Verilator.
# Exits non-zero when the build, the run or the checks fail.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f complexExecStage.f \
    --top-module complexExecStageTb \
    -Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "RESULT: FAIL" sim.log; then
    exit 1
fi
if ! grep -q "RESULT: PASS" sim.log; then
    echo "Simulation ended without a result line"
    exit 1
fi
exit 0

// File: include/tbStimulus.svh
/* Stimulus tasks, scoreboard helpers and reference arithmetic.
   Included inside the complex execution stage testbench module. */
`ifndef TB_STIMULUS_SVH
`define TB_STIMULUS_SVH

function automatic void refreshHeads();
    resPending = (resQ.size() > 0);
    repPending = (repQ.size() > 0);
    if (resPending) begin
        resHead = resQ[0];
        resHeadDue = resDueQ[0];
    end
    if (repPending) begin
        repHead = repQ[0];
        repHeadDue = repDueQ[0];
    end
endfunction

function automatic logic [31:0] refMul(input logic getUpper, input mulCodeType code,
                                       input logic [31:0] a, input logic [31:0] b);
    logic [63:0] full;
    case (code)
        mulSignedSigned: full = $signed(a) * $signed(b);
        mulSignedUnsigned: full = $signed({{32{a[31]}}, a}) * $signed({32'b0, b});
        default: full = {32'b0, a} * {32'b0, b};
    endcase
    return getUpper ? full[63:32] : full[31:0];
endfunction

// Division by zero and signed overflow follow the RISC-V rules
function automatic logic [31:0] refDiv(input divCodeType code,
                                       input logic [31:0] a, input logic [31:0] b);
    logic overflow;
    logic [31:0] sQuot;
    logic [31:0] sRem;
    logic [31:0] q;
    overflow = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
    sQuot = 32'h0;
    sRem = 32'h0;
    // Signed results truncate toward zero
    if (b != 0 && !overflow) begin
        sQuot = $signed(a) / $signed(b);
        sRem = $signed(a) % $signed(b);
    end
    case (code)
        div: q = (b == 0) ? 32'hffff_ffff : overflow ? a : sQuot;
        divu: q = (b == 0) ? 32'hffff_ffff : a / b;
        rem: q = (b == 0) ? a : overflow ? 32'h0 : sRem;
        default: q = (b == 0) ? a : a % b;
    endcase
    return q;
endfunction

task automatic pushResult(input activeListPtr ptr, input logic dataValid,
                          input logic [31:0] data, input int due);
    execResult r;
    r.valid = 1'b1;
    r.dataValid = dataValid;
    r.data = data;
    r.activeListPtr = ptr;
    resQ.push_back(r);
    resDueQ.push_back(due);
    refreshHeads();
endtask

task automatic pushReplay(input activeListPtr ptr, input int due);
    repQ.push_back(ptr);
    repDueQ.push_back(due);
    refreshHeads();
endtask

task automatic nextCycle();
    @(posedge clk);
    #0.5;
endtask

task automatic waitCycles(input int n);
    repeat (n) nextCycle();
endtask

task automatic issueMul(input activeListPtr ptr, input logic getUpper, input mulCodeType code,
                        input logic [31:0] a, input logic [31:0] b, input logic ready,
                        input logic expectOut);
    complexEntry e;
    mulInfo m;
    e = '0;
    m.getUpper = getUpper;
    m.mulCode = code;
    m.pad = 1'b0;
    e.valid = 1'b1;
    e.opType = opMul;
    e.opInfo.asMul = m;
    e.activeListPtr = ptr;
    e.operandA = '{ready: 1'b1, data: a};
    e.operandB = '{ready: ready, data: b};
    if (expectOut) begin
        if (!ready) begin
            pushReplay(ptr, timingOn ? cycleCount + 2 : -1);
        end
        pushResult(ptr, ready, refMul(getUpper, code, a, b),
                   timingOn ? cycleCount + execDepth : -1);
    end
    issue = e;
    nextCycle();
    issue = '0;
endtask

task automatic issueDiv(input activeListPtr ptr, input divCodeType code,
                        input logic [31:0] a, input logic [31:0] b, input logic replay);
    complexEntry e;
    divInfo d;
    e = '0;
    d.divCode = code;
    d.pad = 2'b00;
    e.valid = 1'b1;
    e.replay = replay;
    e.opType = opDiv;
    e.opInfo.asDiv = d;
    e.activeListPtr = ptr;
    e.operandA = '{ready: 1'b1, data: a};
    e.operandB = '{ready: 1'b1, data: b};
    // First pass only starts the divider and comes back as a replay
    if (!replay) begin
        pushReplay(ptr, cycleCount + 2);
    end
    pushResult(ptr, replay, replay ? refDiv(code, a, b) : 32'h0, cycleCount + execDepth);
    issue = e;
    nextCycle();
    issue = '0;
endtask

task automatic waitDrain();
    int n;
    n = 0;
    while ((resQ.size() > 0 || repQ.size() > 0) && n < 100) begin
        nextCycle();
        n++;
    end
    if (resQ.size() > 0 || repQ.size() > 0) begin
        errors++;
        $display("Expected results or replays never appeared");
    end
endtask

task automatic flushFor(input activeListPtr head, input activeListPtr tail);
    flushReq.active = 1'b1;
    flushReq.flushAll = 1'b0;
    flushReq.headPtr = head;
    flushReq.tailPtr = tail;
    nextCycle();
    flushReq = '0;
endtask

`endif

// File: testbench/complexExecStageTb.sv
/* Self-checking testbench for the complex execution stage.
   Run through run.sh, which builds with Verilator and checks the log. */
`timescale 1ns/1ps

module complexExecStageTb;
    import complexOpPkg::*;
    import recoveryPkg::*;

    localparam int execDepth = 3;
    localparam int divCycles = 32;
    localparam real clkPeriod = 4.0;
    // Reset, multiplies, six divide round trips, flush, stall, clear, then margin
    localparam int budgetCycles = 10 + 40 + 6 * (divCycles + 60) + 150 + 60 + 120 + 300;

    logic         clk;
    logic         arstN;
    logic         stall;
    logic         clear;
    complexEntry  issue;
    flushRange    flushReq;
    execResult    result;
    logic         replayValid;
    complexEntry  replayEntry;
    logic         divBusy;
    logic         divFinished;

    int           errors;
    int           cycleCount;
    int           seed;
    logic         timingOn;
    execResult    resQ[$];
    int           resDueQ[$];
    activeListPtr repQ[$];
    int           repDueQ[$];
    logic         resPending;
    execResult    resHead;
    int           resHeadDue;
    logic         repPending;
    activeListPtr repHead;
    int           repHeadDue;
    execResult    seenRes;
    logic         seenReplay;
    activeListPtr seenRepPtr;

    complexExecStage #(
        .execDepth(execDepth),
        .divCycles(divCycles)
    ) complexExecStage_inst (
        .clk(clk),
        .arstN(arstN),
        .stall(stall),
        .clear(clear),
        .issue(issue),
        .flushReq(flushReq),
        .result(result),
        .replayValid(replayValid),
        .replayEntry(replayEntry),
        .divBusy(divBusy),
        .divFinished(divFinished)
    );

    `include "tbStimulus.svh"

    always #2 clk = ~clk;

    always @(posedge clk) cycleCount <= cycleCount + 1;

    // Outputs are settled by the falling edge
    always @(negedge clk) begin
        seenRes <= result;
        seenReplay <= replayValid;
        seenRepPtr <= replayEntry.activeListPtr;
    end

    always @(posedge clk) begin
        #0.1;
        if (seenRes.valid && resQ.size() > 0) begin
            void'(resQ.pop_front());
            void'(resDueQ.pop_front());
        end
        if (seenReplay && repQ.size() > 0) begin
            void'(repQ.pop_front());
            void'(repDueQ.pop_front());
        end
        refreshHeads();
    end

    resultExpected: assert property (@(posedge clk) disable iff (!arstN)
        result.valid |-> resPending)
        else begin
            errors++;
            $display("Unexpected result for pointer %h", seenRes.activeListPtr);
        end

    resultPointer: assert property (@(posedge clk) disable iff (!arstN)
        result.valid && resPending |-> result.activeListPtr == resHead.activeListPtr)
        else begin
            errors++;
            $display("CHECK FAILED result.activeListPtr got %h expected %h",
                     seenRes.activeListPtr, resHead.activeListPtr);
        end

    resultDataValid: assert property (@(posedge clk) disable iff (!arstN)
        result.valid && resPending |-> result.dataValid == resHead.dataValid)
        else begin
            errors++;
            $display("CHECK FAILED result.dataValid got %h expected %h",
                     seenRes.dataValid, resHead.dataValid);
        end

    resultData: assert property (@(posedge clk) disable iff (!arstN)
        result.valid && resPending && resHead.dataValid |-> result.data == resHead.data)
        else begin
            errors++;
            $display("CHECK FAILED result.data got %h expected %h",
                     seenRes.data, resHead.data);
        end

    resultLatency: assert property (@(posedge clk) disable iff (!arstN)
        result.valid && resPending && resHeadDue >= 0 |-> cycleCount == resHeadDue)
        else begin
            errors++;
            $display("Result for pointer %h arrived at cycle %0d instead of %0d",
                     seenRes.activeListPtr, cycleCount, resHeadDue);
        end

    replayExpected: assert property (@(posedge clk) disable iff (!arstN)
        replayValid |-> repPending && replayEntry.activeListPtr == repHead)
        else begin
            errors++;
            $display("CHECK FAILED replayEntry.activeListPtr got %h expected %h",
                     seenRepPtr, repHead);
        end

    replayLatency: assert property (@(posedge clk) disable iff (!arstN)
        replayValid && repPending && repHeadDue >= 0 |-> cycleCount == repHeadDue)
        else begin
            errors++;
            $display("Replay for pointer %h came at the wrong cycle", seenRepPtr);
        end

    quietDuringStall: assert property (@(posedge clk) disable iff (!arstN)
        stall |-> !result.valid)
        else begin
            errors++;
            $display("CHECK FAILED result.valid got %h expected 0 during stall", seenRes.valid);
        end

    initial begin
        #(budgetCycles * clkPeriod);
        $display("Watchdog expired before the tests finished");
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        int n;
        int kind;
        logic [31:0] a;
        logic [31:0] b;
        divCodeType codes[6];
        logic [31:0] dividends[6];
        logic [31:0] divisors[6];

        clk = 1'b0;
        arstN = 1'b0;
        stall = 1'b0;
        clear = 1'b0;
        issue = '0;
        flushReq = '0;
        errors = 0;
        cycleCount = 0;
        seed = 32'hc452_b341;
        timingOn = 1'b1;
        refreshHeads();
        waitCycles(5);
        arstN = 1'b1;
        assert (!result.valid && !replayValid && !divBusy && !divFinished) else begin
            errors++;
            $display("Outputs not idle after reset");
        end

        // Back-to-back multiplies of all four kinds
        for (int i = 0; i < 16; i++) begin
            a = $random(seed);
            b = $random(seed);
            kind = i % 4;
            issueMul(6'(i), kind != 0, mulCodeType'(kind == 0 ? 0 : kind - 1), a, b, 1'b1, 1'b1);
        end
        issueMul(6'd16, 1'b1, mulSignedSigned, 32'h8000_0000, 32'hffff_ffff, 1'b1, 1'b1);
        waitDrain();

        // Unready operand comes back as a replay
        issueMul(6'd17, 1'b0, mulSignedSigned, 32'd5, 32'd6, 1'b0, 1'b1);
        issueMul(6'd18, 1'b0, mulSignedSigned, 32'd7, 32'd9, 1'b1, 1'b1);
        waitDrain();

        codes = '{div, rem, divu, rem, div, rem};
        dividends = '{32'd100, 32'hffff_ff9c, 32'd1234, 32'hdead_beef,
                      32'h8000_0000, 32'h8000_0000};
        divisors = '{32'd7, 32'd7, 32'd0, 32'd0, 32'hffff_ffff, 32'hffff_ffff};
        for (int i = 0; i < 6; i++) begin
            issueDiv(6'(20 + i), codes[i], dividends[i], divisors[i], 1'b0);
            waitDrain();
            assert (divBusy) else begin
                errors++;
                $display("Divider not busy after first pass of pointer %h", 6'(20 + i));
            end
            n = 0;
            while (!divFinished && n < divCycles + 20) begin
                nextCycle();
                n++;
            end
            assert (divFinished) else begin
                errors++;
                $display("Divider never finished");
            end
            issueDiv(6'(20 + i), codes[i], dividends[i], divisors[i], 1'b1);
            waitDrain();
            assert (!divFinished && !divBusy) else begin
                errors++;
                $display("Divider not released after the result was collected");
            end
        end

        // Flush wrapping past the top of the pointer space hits 63 and 0
        issueMul(6'd61, 1'b0, mulSignedSigned, $random(seed), $random(seed), 1'b1, 1'b1);
        issueMul(6'd62, 1'b0, mulSignedSigned, $random(seed), $random(seed), 1'b1, 1'b1);
        issueMul(6'd63, 1'b0, mulSignedSigned, $random(seed), $random(seed), 1'b1, 1'b0);
        issueMul(6'd0, 1'b0, mulSignedSigned, $random(seed), $random(seed), 1'b1, 1'b0);
        issueMul(6'd1, 1'b0, mulSignedSigned, $random(seed), $random(seed), 1'b1, 1'b1);
        flushFor(6'd63, 6'd1);
        waitDrain();
        waitCycles(4);

        issueDiv(6'd40, divu, 32'd99, 32'd3, 1'b0);
        waitDrain();
        flushFor(6'd40, 6'd41);
        assert (!divBusy && !divFinished) else begin
            errors++;
            $display("Divider still reserved after its owner was flushed");
        end

        // Stall with a stray issue that must be ignored
        timingOn = 1'b0;
        issueMul(6'd30, 1'b1, mulUnsignedUnsigned, $random(seed), $random(seed), 1'b1, 1'b1);
        issueMul(6'd31, 1'b0, mulSignedSigned, $random(seed), $random(seed), 1'b1, 1'b1);
        issueMul(6'd32, 1'b1, mulSignedUnsigned, $random(seed), $random(seed), 1'b1, 1'b1);
        stall = 1'b1;
        issue.valid = 1'b1;
        issue.activeListPtr = 6'd45;
        waitCycles(4);
        stall = 1'b0;
        issue = '0;
        waitDrain();
        timingOn = 1'b1;

        // Clear empties the pipeline and frees the divider
        issueDiv(6'd50, div, 32'd77, 32'd5, 1'b0);
        waitDrain();
        issueMul(6'd51, 1'b0, mulSignedSigned, 32'd3, 32'd4, 1'b1, 1'b0);
        issueMul(6'd52, 1'b0, mulSignedSigned, 32'd5, 32'd6, 1'b1, 1'b0);
        clear = 1'b1;
        nextCycle();
        clear = 1'b0;
        assert (!divBusy && !divFinished) else begin
            errors++;
            $display("Divider still reserved after clear");
        end
        waitCycles(6);

        waitDrain();
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end
        else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
